// File: verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0] word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // RV32I major opcodes of the supported subset.
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_e;

    typedef enum logic {a_rs1, a_pc} alu_a_sel_e;

    // b_four gives the link value pc + 4 for JAL.
    typedef enum logic [1:0] {b_rs2, b_imm, b_four} alu_b_sel_e;

    typedef enum logic [1:0] {fwd_reg, fwd_mem, fwd_wb} fwd_sel_e;

    typedef enum logic [2:0] {
        br_none, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu, br_jal
    } br_kind_e;

    typedef struct packed {
        alu_op_e    alu_op;
        alu_a_sel_e alu_a_sel;
        alu_b_sel_e alu_b_sel;
        br_kind_e   br_kind;
        logic       mem_read;
        logic       mem_write;
        logic       reg_write;
    } ctrl_t;

    typedef struct packed {
        word_t     pc;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        ctrl_t     ctrl;
    } id_ex_t;

    typedef struct packed {
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t rd;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
    } ex_mem_t;

    typedef struct packed {
        word_t     alu_result;
        word_t     load_data;
        reg_addr_t rd;
        logic      mem_read;
        logic      reg_write;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: verilog/stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     hold,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // A zero payload has every write enable low, so it is a bubble.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter rv_pkg::word_t reset_pc = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          stall,
    input  logic          flush_fd,
    input  logic          taken,
    input  rv_pkg::word_t target,
    input  rv_pkg::word_t imem_data,
    output rv_pkg::word_t imem_addr,
    output rv_pkg::word_t fd_pc,
    output rv_pkg::word_t fd_instr
);
    import rv_pkg::*;

    word_t pc;

    // A taken branch wins over a load-use hold.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_pc;
        end else if (taken) begin
            pc <= target;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    assign imem_addr = pc;

    // An all-zero word is not a valid opcode and decodes as a bubble.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fd_pc    <= '0;
            fd_instr <= '0;
        end else if (flush_fd) begin
            fd_pc    <= '0;
            fd_instr <= '0;
        end else if (!stall) begin
            fd_pc    <= pc;
            fd_instr <= imem_data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  rv_pkg::word_t     instr,
    output rv_pkg::ctrl_t     ctrl,
    output rv_pkg::word_t     imm,
    output rv_pkg::reg_addr_t rs1,
    output rv_pkg::reg_addr_t rs2,
    output rv_pkg::reg_addr_t rd
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_5;
    logic       use_rs1;
    logic       use_rs2;
    alu_op_e    alu_fn;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7_5 = instr[30];

    // Bit 30 selects SUB only for register-register ops; for ADDI it is immediate.
    always_comb begin
        case (funct3)
            3'b000:  alu_fn = (opcode == op_reg && funct7_5) ? alu_sub : alu_add;
            3'b001:  alu_fn = alu_sll;
            3'b010:  alu_fn = alu_slt;
            3'b011:  alu_fn = alu_sltu;
            3'b100:  alu_fn = alu_xor;
            3'b101:  alu_fn = funct7_5 ? alu_sra : alu_srl;
            3'b110:  alu_fn = alu_or;
            default: alu_fn = alu_and;
        endcase
    end

    always_comb begin
        ctrl.alu_op    = alu_add;
        ctrl.alu_a_sel = a_rs1;
        ctrl.alu_b_sel = b_rs2;
        ctrl.br_kind   = br_none;
        ctrl.mem_read  = 1'b0;
        ctrl.mem_write = 1'b0;
        ctrl.reg_write = 1'b0;
        imm            = '0;
        use_rs1        = 1'b0;
        use_rs2        = 1'b0;
        case (opcode)
            op_reg: begin
                ctrl.alu_op    = alu_fn;
                ctrl.reg_write = 1'b1;
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
            end
            op_imm: begin
                ctrl.alu_op    = alu_fn;
                ctrl.alu_b_sel = b_imm;
                ctrl.reg_write = 1'b1;
                imm            = {{20{instr[31]}}, instr[31:20]};
                use_rs1        = 1'b1;
            end
            op_lui: begin
                ctrl.alu_op    = alu_pass_b;
                ctrl.alu_b_sel = b_imm;
                ctrl.reg_write = 1'b1;
                imm            = {instr[31:12], 12'b0};
            end
            op_load: begin
                ctrl.alu_b_sel = b_imm;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = {{20{instr[31]}}, instr[31:20]};
                use_rs1        = 1'b1;
            end
            op_store: begin
                ctrl.alu_b_sel = b_imm;
                ctrl.mem_write = 1'b1;
                imm            = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
            end
            op_branch: begin
                case (funct3)
                    3'b000:  ctrl.br_kind = br_beq;
                    3'b001:  ctrl.br_kind = br_bne;
                    3'b100:  ctrl.br_kind = br_blt;
                    3'b101:  ctrl.br_kind = br_bge;
                    3'b110:  ctrl.br_kind = br_bltu;
                    3'b111:  ctrl.br_kind = br_bgeu;
                    default: ctrl.br_kind = br_none;
                endcase
                imm     = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            op_jal: begin
                ctrl.alu_a_sel = a_pc;
                ctrl.alu_b_sel = b_four;
                ctrl.br_kind   = br_jal;
                ctrl.reg_write = 1'b1;
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
            end
        endcase
    end

    // Unused source fields read as x0 so they never forward or stall.
    assign rs1 = use_rs1 ? instr[19:15] : '0;
    assign rs2 = use_rs2 ? instr[24:20] : '0;
    assign rd  = instr[11:7];

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic              clk,
    input  logic              arst_n,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    input  rv_pkg::mem_wb_t   wb,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    output rv_pkg::word_t     wb_data
);
    import rv_pkg::*;

    word_t regs [32];
    logic  wr_en;

    assign wb_data = wb.mem_read ? wb.load_data : wb.alu_result;
    assign wr_en   = wb.reg_write && (wb.rd != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb_data;
        end
    end

    // Same-cycle bypass of the value being written back.
    function automatic word_t read_port(reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wr_en && wb.rd == addr) begin
            value = wb_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

endmodule

`default_nettype wire

// File: verilog/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  rv_pkg::id_ex_t   de,
    input  rv_pkg::fwd_sel_e fwd_a,
    input  rv_pkg::fwd_sel_e fwd_b,
    input  rv_pkg::word_t    mem_fwd,
    input  rv_pkg::word_t    wb_fwd,
    output rv_pkg::ex_mem_t  em,
    output logic             taken,
    output rv_pkg::word_t    target
);
    import rv_pkg::*;

    word_t rs1_val;
    word_t rs2_val;
    word_t op_a;
    word_t op_b;
    word_t result;
    logic  eq;
    logic  lt;
    logic  ltu;

    function automatic word_t pick(fwd_sel_e sel, word_t reg_val, word_t mem_val,
                                   word_t wb_val);
        word_t value;
        case (sel)
            fwd_mem: value = mem_val;
            fwd_wb:  value = wb_val;
            default: value = reg_val;
        endcase
        return value;
    endfunction

    assign rs1_val = pick(fwd_a, de.rs1_data, mem_fwd, wb_fwd);
    assign rs2_val = pick(fwd_b, de.rs2_data, mem_fwd, wb_fwd);

    assign op_a = (de.ctrl.alu_a_sel == a_pc) ? de.pc : rs1_val;

    always_comb begin
        case (de.ctrl.alu_b_sel)
            b_imm:   op_b = de.imm;
            b_four:  op_b = 32'd4;
            default: op_b = rs2_val;
        endcase
    end

    always_comb begin
        case (de.ctrl.alu_op)
            alu_sub:    result = op_a - op_b;
            alu_sll:    result = op_a << op_b[4:0];
            alu_slt:    result = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu:   result = {31'b0, op_a < op_b};
            alu_xor:    result = op_a ^ op_b;
            alu_srl:    result = op_a >> op_b[4:0];
            alu_sra:    result = $unsigned($signed(op_a) >>> op_b[4:0]);
            alu_or:     result = op_a | op_b;
            alu_and:    result = op_a & op_b;
            alu_pass_b: result = op_b;
            default:    result = op_a + op_b;
        endcase
    end

    // Branch compare works on the forwarded sources, not the ALU operands.
    assign eq  = (rs1_val == rs2_val);
    assign lt  = ($signed(rs1_val) < $signed(rs2_val));
    assign ltu = (rs1_val < rs2_val);

    always_comb begin
        case (de.ctrl.br_kind)
            br_beq:  taken = eq;
            br_bne:  taken = !eq;
            br_blt:  taken = lt;
            br_bge:  taken = !lt;
            br_bltu: taken = ltu;
            br_bgeu: taken = !ltu;
            br_jal:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign target = de.pc + de.imm;

    assign em.alu_result = result;
    assign em.store_data = rs2_val;
    assign em.rd         = de.rd;
    assign em.mem_read   = de.ctrl.mem_read;
    assign em.mem_write  = de.ctrl.mem_write;
    assign em.reg_write  = de.ctrl.reg_write;

endmodule

`default_nettype wire

// File: verilog/hazard_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl (
    input  rv_pkg::reg_addr_t id_rs1,
    input  rv_pkg::reg_addr_t id_rs2,
    input  rv_pkg::id_ex_t    de,
    input  rv_pkg::reg_addr_t mem_rd,
    input  rv_pkg::reg_addr_t wb_rd,
    input  logic              mem_reg_write,
    input  logic              wb_reg_write,
    input  logic              taken,
    output rv_pkg::fwd_sel_e  fwd_a,
    output rv_pkg::fwd_sel_e  fwd_b,
    output logic              stall,
    output logic              flush_fd,
    output logic              flush_de
);
    import rv_pkg::*;

    logic load_use;

    // The memory stage holds the younger result, so it is checked first.
    function automatic fwd_sel_e pick_source(reg_addr_t src);
        fwd_sel_e sel;
        sel = fwd_reg;
        if (src != '0 && mem_reg_write && mem_rd == src) begin
            sel = fwd_mem;
        end else if (src != '0 && wb_reg_write && wb_rd == src) begin
            sel = fwd_wb;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a = pick_source(de.rs1);
        fwd_b = pick_source(de.rs2);
    end

    // Load data only exists after the memory stage.
    assign load_use = de.ctrl.mem_read && (de.rd != '0)
                      && (de.rd == id_rs1 || de.rd == id_rs2);

    assign stall    = load_use && !taken;
    assign flush_fd = taken;
    assign flush_de = taken || load_use;

endmodule

`default_nettype wire

// File: verilog/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter rv_pkg::word_t reset_pc = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          arst_n,
    output rv_pkg::word_t imem_addr,
    input  rv_pkg::word_t imem_data,
    output rv_pkg::word_t dmem_addr,
    output rv_pkg::word_t dmem_wdata,
    output logic          dmem_we,
    input  rv_pkg::word_t dmem_rdata
);
    import rv_pkg::*;

    word_t     fd_pc;
    word_t     fd_instr;
    ctrl_t     id_ctrl;
    word_t     id_imm;
    reg_addr_t id_rs1;
    reg_addr_t id_rs2;
    reg_addr_t id_rd;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     wb_data;
    id_ex_t    id_payload;
    id_ex_t    de;
    ex_mem_t   ex_payload;
    ex_mem_t   em;
    mem_wb_t   mem_payload;
    mem_wb_t   wb;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    logic      stall;
    logic      flush_fd;
    logic      flush_de;
    logic      taken;
    word_t     target;

    fetch_unit #(.reset_pc(reset_pc)) u_fetch (
        .clk(clk), .arst_n(arst_n), .stall(stall), .flush_fd(flush_fd),
        .taken(taken), .target(target), .imem_data(imem_data),
        .imem_addr(imem_addr), .fd_pc(fd_pc), .fd_instr(fd_instr)
    );

    decoder u_decoder (
        .instr(fd_instr), .ctrl(id_ctrl), .imm(id_imm),
        .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd)
    );

    reg_file u_reg_file (
        .clk(clk), .arst_n(arst_n), .rs1(id_rs1), .rs2(id_rs2), .wb(wb),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .wb_data(wb_data)
    );

    assign id_payload = '{pc: fd_pc, rs1_data: rs1_data, rs2_data: rs2_data, imm: id_imm,
                          rs1: id_rs1, rs2: id_rs2, rd: id_rd, ctrl: id_ctrl};

    stage_reg #(.payload_t(id_ex_t)) u_de_reg (
        .clk(clk), .arst_n(arst_n), .hold(1'b0), .flush(flush_de), .d(id_payload), .q(de)
    );

    execute u_execute (
        .de(de), .fwd_a(fwd_a), .fwd_b(fwd_b), .mem_fwd(em.alu_result), .wb_fwd(wb_data),
        .em(ex_payload), .taken(taken), .target(target)
    );

    stage_reg #(.payload_t(ex_mem_t)) u_em_reg (
        .clk(clk), .arst_n(arst_n), .hold(1'b0), .flush(1'b0), .d(ex_payload), .q(em)
    );

    // Memory stage drives the data port straight from the register.
    assign dmem_addr  = em.alu_result;
    assign dmem_wdata = em.store_data;
    assign dmem_we    = em.mem_write;

    assign mem_payload = '{alu_result: em.alu_result, load_data: dmem_rdata, rd: em.rd,
                           mem_read: em.mem_read, reg_write: em.reg_write};

    stage_reg #(.payload_t(mem_wb_t)) u_mw_reg (
        .clk(clk), .arst_n(arst_n), .hold(1'b0), .flush(1'b0), .d(mem_payload), .q(wb)
    );

    hazard_ctrl u_hazard (
        .id_rs1(id_rs1), .id_rs2(id_rs2), .de(de),
        .mem_rd(em.rd), .wb_rd(wb.rd),
        .mem_reg_write(em.reg_write), .wb_reg_write(wb.reg_write), .taken(taken),
        .fwd_a(fwd_a), .fwd_b(fwd_b),
        .stall(stall), .flush_fd(flush_fd), .flush_de(flush_de)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter realtime period       = 40.0,
    parameter int      reset_cycles = 2
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2.0) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: testbench/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;
    import rv_pkg::*;

    localparam word_t reset_pc  = 32'h0000_0100;
    localparam word_t self_loop = 32'h0000_006f;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    logic      clk;
    logic      clk_rst_n;
    logic      tst_rst_n;
    logic      dut_rst_n;
    word_t     imem_addr;
    word_t     imem_data;
    word_t     dmem_addr;
    word_t     dmem_wdata;
    logic      dmem_we;
    word_t     dmem_rdata;

    word_t     imem [1024];
    word_t     dmem [64];
    word_t     mdl_mem [64];
    word_t     prog [$];
    store_t    exp_stores [$];
    string     test_name;
    int        test_no;
    int        exp_total;
    int        seen;
    int        cycles;
    int        cycle_limit;

    tb_clock #(.period(40.0), .reset_cycles(2)) u_clock (.clk(clk), .arst_n(clk_rst_n));

    assign dut_rst_n  = clk_rst_n & tst_rst_n;
    assign imem_data  = imem[imem_addr[11:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    rv_core #(.reset_pc(reset_pc)) dut0 (
        .clk(clk), .arst_n(dut_rst_n), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_rdata(dmem_rdata)
    );

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end
    end

    function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    // LUI plus ADDI, with the upper part rounded for the sign of the low part.
    task automatic load_const(reg_addr_t rd, word_t value);
        word_t upper;
        upper = (value + 32'h800) >> 12;
        prog.push_back({upper[19:0], rd, op_lui});
        prog.push_back(enc_i(value[11:0], rd, 3'b000, rd, op_imm));
    endtask

    // Unused instruction words read as bubbles.
    task automatic load_memories();
        for (int i = 0; i < 1024; i++) imem[i] = '0;
        foreach (prog[i]) imem[reset_pc[11:2] + i] = prog[i];
        for (int i = 0; i < 64; i++) begin
            dmem[i]    = word_t'(i * 4) * 32'h9e37_79b9 + 32'h1234_5678 + word_t'(test_no);
            mdl_mem[i] = dmem[i];
        end
    endtask

    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Instruction-level model; fills exp_stores and returns the executed count.
    function automatic int ref_run();
        word_t r [32];
        word_t pc;
        word_t ins;
        word_t a;
        word_t b;
        word_t addr;
        word_t imm_i;
        word_t imm_s;
        word_t imm_b;
        word_t imm_j;
        logic  cond;
        int    n;
        int    idx;
        for (int i = 0; i < 32; i++) r[i] = '0;
        exp_stores.delete();
        pc = reset_pc;
        n  = 0;
        while (n < 2000) begin
            idx = int'((pc - reset_pc) >> 2);
            if (idx >= prog.size()) return n;
            ins = prog[idx];
            if (ins == self_loop) return n;
            n++;
            a     = r[ins[19:15]];
            b     = r[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            pc    = pc + 4;
            case (ins[6:0])
                op_reg: r[ins[11:7]] = alu_ref(ins[14:12], ins[30], a, b);
                op_imm: r[ins[11:7]] = alu_ref(ins[14:12],
                                               ins[30] && ins[14:12] == 3'b101, a, imm_i);
                op_lui: r[ins[11:7]] = {ins[31:12], 12'b0};
                op_load: begin
                    addr = a + imm_i;
                    r[ins[11:7]] = mdl_mem[addr[7:2]];
                end
                op_store: begin
                    addr = a + imm_s;
                    exp_stores.push_back('{addr: addr, data: b});
                    mdl_mem[addr[7:2]] = b;
                end
                op_branch: begin
                    case (ins[14:12])
                        3'b000:  cond = (a == b);
                        3'b001:  cond = (a != b);
                        3'b100:  cond = ($signed(a) < $signed(b));
                        3'b101:  cond = ($signed(a) >= $signed(b));
                        3'b110:  cond = (a < b);
                        default: cond = (a >= b);
                    endcase
                    if (cond) pc = pc - 4 + imm_b;
                end
                op_jal: begin
                    r[ins[11:7]] = pc;
                    pc = pc - 4 + imm_j;
                end
                default: begin
                end
            endcase
            r[0] = '0;
        end
        return n;
    endfunction

    task automatic check_store_addr(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: store address expected %h, actual %h", name, expected, actual);
            $display("tests failed");
            $fatal(1, "store address mismatch");
        end
    endtask

    task automatic check_store_data(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: store data expected %h, actual %h", name, expected, actual);
            $display("tests failed");
            $fatal(1, "store data mismatch");
        end
    endtask

    task automatic check_store_count(string name, int expected, int actual);
        if (expected != actual) begin
            $display("[ERROR] %s: store count expected %0d, actual %0d", name, expected, actual);
            $display("tests failed");
            $fatal(1, "store count mismatch");
        end
    endtask

    task automatic check_fetch_addr(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: first fetch address expected %h, actual %h",
                     name, expected, actual);
            $display("tests failed");
            $fatal(1, "fetch address mismatch");
        end
    endtask

    task automatic check_no_store(string when);
        if (dmem_we) begin
            $display("The core raised dmem_we %s.", when);
            $display("tests failed");
            $fatal(1, "unexpected store");
        end
    endtask

    // Stores are compared at the falling edge, half a cycle after they settle.
    // Every store is counted, so a surplus shows up in the count.
    always @(negedge clk) begin
        if (!dut_rst_n) begin
            check_no_store("while held in reset");
        end else if (dmem_we) begin
            if (exp_stores.size() != 0) begin
                check_store_addr(test_name, exp_stores[0].addr, dmem_addr);
                check_store_data(test_name, exp_stores[0].data, dmem_wdata);
                void'(exp_stores.pop_front());
            end
            seen++;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("The core stopped storing in test %s after %0d cycles.", test_name, cycles);
            $display("tests failed");
            $fatal(1, "timeout");
        end
    end

    task automatic build_alu_chain();
        logic [2:0] r_f3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
        logic       r_alt [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
        logic [2:0] i_f3 [9] = '{0, 2, 3, 4, 6, 7, 1, 5, 5};
        logic       i_alt [9] = '{0, 0, 0, 0, 0, 0, 0, 0, 1};
        logic [11:0] imm;
        prog.delete();
        for (int i = 0; i < 20; i++) begin
            load_const(10, $urandom);
            load_const(11, (i % 2) ? $urandom : $urandom_range(0, 40));
            if (i < 10) begin
                prog.push_back(enc_r(r_alt[i] ? 7'h20 : 7'h00, 11, 10, r_f3[i], 1));
            end else if (i < 19) begin
                imm = $urandom;
                if (i_f3[i-10] == 3'b001 || i_f3[i-10] == 3'b101) begin
                    imm = {1'b0, i_alt[i-10], 5'b0, imm[4:0]};
                end
                prog.push_back(enc_i(imm, 10, i_f3[i-10], 1, op_imm));
            end else begin
                prog.push_back({20'($urandom), 5'd1, op_lui});
            end
            // Next uses the memory-stage copy, the one after the write-back copy.
            prog.push_back(enc_r(7'h00, 1, 1, 3'b000, 2));
            prog.push_back(enc_r(7'h20, 1, 0, 3'b000, 3));
            prog.push_back(enc_s(12'h080, 1, 0));
            prog.push_back(enc_s(12'h084, 2, 0));
            prog.push_back(enc_s(12'h088, 3, 0));
        end
        prog.push_back(self_loop);
    endtask

    task automatic build_load_use();
        prog.delete();
        prog.push_back(enc_i(12'h010, 0, 3'b010, 1, op_load));
        prog.push_back(enc_r(7'h00, 1, 1, 3'b000, 2));
        prog.push_back(enc_s(12'h014, 2, 0));
        prog.push_back(enc_i(12'h018, 0, 3'b010, 3, op_load));
        prog.push_back(enc_s(12'h01c, 3, 0));
        prog.push_back(enc_i(12'h020, 0, 3'b010, 4, op_load));
        prog.push_back(enc_r(7'h00, 4, 0, 3'b000, 5));
        prog.push_back(enc_s(12'h024, 5, 0));
        prog.push_back(self_loop);
    endtask

    task automatic build_branches();
        logic [2:0] b_f3 [6] = '{0, 1, 4, 5, 6, 7};
        word_t      op_a [3] = '{32'd5, 32'hffff_fffd, 32'd4};
        word_t      op_b [3] = '{32'd5, 32'd4, 32'hffff_fffd};
        prog.delete();
        load_const(3, 32'hbad0_0bad);
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 3; p++) begin
                load_const(1, op_a[p]);
                load_const(2, op_b[p]);
                prog.push_back(enc_b(13'd12, 2, 1, b_f3[k]));
                prog.push_back(enc_s(12'h040, 3, 0));
                prog.push_back(enc_s(12'h044, 3, 0));
                prog.push_back(enc_i(12'(k * 3 + p), 0, 3'b000, 4, op_imm));
                prog.push_back(enc_s(12'h048, 4, 0));
            end
        end
        prog.push_back(enc_j(21'd8, 5));
        prog.push_back(enc_s(12'h040, 3, 0));
        prog.push_back(enc_s(12'h04c, 5, 0));
        prog.push_back(self_loop);
    endtask

    task automatic build_random();
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        prog.delete();
        for (int i = 0; i < 30; i++) begin
            f3  = $urandom;
            imm = $urandom;
            alt = (f3 == 3'b000 || f3 == 3'b101) ? 1'($urandom) : 1'b0;
            case ($urandom_range(0, 3))
                0: prog.push_back(enc_r(alt ? 7'h20 : 7'h00, $urandom_range(0, 7),
                                        $urandom_range(0, 7), f3, $urandom_range(1, 7)));
                1: begin
                    if (f3 == 3'b001 || f3 == 3'b101) imm = {1'b0, alt, 5'b0, imm[4:0]};
                    prog.push_back(enc_i(imm, $urandom_range(0, 7), f3,
                                         $urandom_range(1, 7), op_imm));
                end
                2: prog.push_back(enc_i(12'(4 * $urandom_range(0, 63)), 0, 3'b010,
                                        $urandom_range(1, 7), op_load));
                default: prog.push_back(enc_s(12'(4 * $urandom_range(0, 63)),
                                              $urandom_range(0, 7), 0));
            endcase
        end
        prog.push_back(self_loop);
    endtask

    task automatic run_test(string name);
        int executed;
        @(posedge clk);
        tst_rst_n <= 1'b0;
        test_name = name;
        test_no++;
        load_memories();
        executed  = ref_run();
        exp_total = exp_stores.size();
        seen      = 0;
        cycle_limit += 4 * executed;
        repeat (2) @(posedge clk);
        tst_rst_n <= 1'b1;
        @(negedge clk);
        check_fetch_addr(name, reset_pc, imem_addr);
        check_no_store("in the first cycle after reset");
        @(negedge clk);
        check_no_store("in the second cycle after reset");
        while (seen < exp_total) @(posedge clk);
        repeat (10) @(posedge clk);
        check_store_count(name, exp_total, seen);
    endtask

    initial begin
        tst_rst_n   = 1'b1;
        test_no     = 0;
        seen        = 0;
        exp_total   = 0;
        cycles      = 0;
        cycle_limit = 200;
        test_name   = "startup";
        load_memories();
        void'($urandom(32'h59d2));
        build_alu_chain();
        run_test("alu_chain");
        build_load_use();
        run_test("load_use");
        build_branches();
        run_test("control_flow");
        for (int t = 0; t < 20; t++) begin
            build_random();
            run_test($sformatf("random_%0d", t));
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
verilog/rv_pkg.sv
verilog/stage_reg.sv
verilog/fetch_unit.sv
verilog/decoder.sv
verilog/reg_file.sv
verilog/execute.sv
verilog/hazard_ctrl.sv
verilog/rv_core.sv
testbench/tb_clock.sv
testbench/tb_core.sv
